//--- hdl/controlPkg.sv
`default_nettype none

package controlPkg;

	// Instruction word fields
	localparam int instrWidth = 32;
	localparam int classMsb = 31;
	localparam int classLsb = 29;
	localparam int funcMsb = 28;
	localparam int funcLsb = 24;
	// Condition code overlaps the low function bits
	localparam int condMsb = 25;
	localparam int condLsb = 22;
	localparam int aluOpWidth = 5;

	typedef enum logic [2:0] {
		classNop = 3'b000,
		classAlu = 3'b001,
		classConst = 3'b010,
		classMem = 3'b100,
		classBranch = 3'b101,
		classJump = 3'b110
	} instrClass_e;

	typedef enum logic [aluOpWidth-1:0] {
		aluAdd = 5'b00000,
		aluAddInc = 5'b00001,
		aluBeq = 5'b00010,
		aluIncA = 5'b00011,
		aluSubDec = 5'b00100,
		aluSub = 5'b00101,
		aluDecA = 5'b00110,
		aluBne = 5'b00111,
		aluLsl = 5'b01000,
		aluAsr = 5'b01001,
		aluJumpTarget = 5'b01010,
		aluLch = 5'b01011,
		aluLcl = 5'b01100,
		aluZeros = 5'b10000,
		aluAnd = 5'b10001,
		aluAndNotA = 5'b10010,
		aluPassB = 5'b10011,
		aluAndNotB = 5'b10100,
		aluPassA = 5'b10101,
		aluXor = 5'b10110,
		aluOr = 5'b10111,
		aluNand = 5'b11000,
		aluXnor = 5'b11001,
		aluPassNotA = 5'b11010,
		aluOrNotA = 5'b11011,
		aluPassNotB = 5'b11100,
		aluOrNotB = 5'b11101,
		aluNor = 5'b11110,
		aluOnes = 5'b11111
	} aluOp_e;

	typedef enum logic [3:0] {
		jtZero = 4'd0,
		jtOverflow = 4'd1,
		jtNeg = 4'd2,
		jtNegZero = 4'd3,
		jtCarry = 4'd4,
		jfZero = 4'd5,
		jfOverflow = 4'd6,
		jfNeg = 4'd7,
		jfNegZero = 4'd8,
		jfCarry = 4'd9
	} jumpCond_e;

	typedef enum logic [1:0] {
		fromAlu = 2'b00,
		fromMem = 2'b01,
		fromPc = 2'b10
	} memToReg_e;

	typedef enum logic [1:0] {
		extNone = 2'b00,
		extHigh = 2'b01,
		extLow = 2'b10
	} signExt_e;

	typedef struct packed {
		logic branch;
		logic memReadN;
		logic memWriteN;
		memToReg_e memToReg;
		aluOp_e aluOp;
		logic aluSrc;
		logic regWrite;
		logic registerB;
		logic jumpRegister;
		signExt_e signExt;
	} controlWord_t;

	// Reset and nop word with both strobes idle high
	localparam controlWord_t idleWord = '{
		branch: 1'b0, memReadN: 1'b1, memWriteN: 1'b1, memToReg: fromAlu,
		aluOp: aluAdd, aluSrc: 1'b0, regWrite: 1'b0, registerB: 1'b0,
		jumpRegister: 1'b0, signExt: extNone
	};

	localparam controlWord_t condJumpWord = '{
		branch: 1'b1, memReadN: 1'b1, memWriteN: 1'b1, memToReg: fromAlu,
		aluOp: aluJumpTarget, aluSrc: 1'b1, regWrite: 1'b0, registerB: 1'b0,
		jumpRegister: 1'b0, signExt: extNone
	};

endpackage

`default_nettype wire

//--- hdl/decodeIf.sv
`timescale 1ns/10ps
`default_nettype none

interface decodeIf import controlPkg::*; ();

	controlWord_t word;
	logic known;
	logic condJump;
	jumpCond_e cond;

	modport decoder (
		output word, known, condJump, cond
	);

	modport stage (
		input word, known, condJump
	);

	// Condition evaluation only needs the code
	modport check (
		input cond
	);

endinterface

`default_nettype wire

//--- hdl/jumpCondition.sv
`timescale 1ns/10ps
`default_nettype none

module jumpCondition import controlPkg::*; (
	decodeIf.check decode,
	input logic zero,
	input logic overflow,
	input logic carry,
	input logic neg,
	output logic taken
);

	always_comb begin
		case (decode.cond)
			jtZero: taken = zero;
			jtOverflow: taken = overflow;
			jtNeg: taken = neg;
			jtNegZero: taken = neg || zero;
			jtCarry: taken = carry;
			jfZero: taken = !zero;
			jfOverflow: taken = !overflow;
			jfNeg: taken = !neg;
			// Not the inverse of jtNegZero
			jfNegZero: taken = !neg || !zero;
			jfCarry: taken = !carry;
			default: taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder import controlPkg::*; (
	decodeIf.decoder decode,
	input logic [instrWidth-1:0] instruction
);

	instrClass_e instrClass;
	logic [aluOpWidth-1:0] funcField;

	assign instrClass = instrClass_e'(instruction[classMsb:classLsb]);
	assign funcField = instruction[funcMsb:funcLsb];
	assign decode.cond = jumpCond_e'(instruction[condMsb:condLsb]);

	always_comb begin
		decode.word = idleWord;
		decode.known = 1'b0;
		decode.condJump = 1'b0;
		case (instrClass)
			classNop: begin
				decode.known = 1'b1;
			end
			classAlu: begin
				decode.word.aluOp = aluOp_e'(funcField);
				decode.word.regWrite = 1'b1;
				// Only 24 of the 32 codes are ALU functions
				case (aluOp_e'(funcField))
					aluAdd, aluAddInc, aluIncA, aluSubDec,
					aluSub, aluDecA, aluLsl, aluAsr,
					aluZeros, aluAnd, aluAndNotA, aluPassB,
					aluAndNotB, aluPassA, aluXor, aluOr,
					aluNand, aluXnor, aluPassNotA, aluOrNotA,
					aluPassNotB, aluOrNotB, aluNor, aluOnes: begin
						decode.known = 1'b1;
					end
					default: begin
						decode.known = 1'b0;
					end
				endcase
			end
			classMem: begin
				decode.known = 1'b1;
				decode.word.aluSrc = 1'b1;
				if (funcField[0]) begin
					decode.word.memWriteN = 1'b0;
					decode.word.registerB = 1'b1;
				end else begin
					decode.word.memReadN = 1'b0;
					decode.word.memToReg = fromMem;
					decode.word.regWrite = 1'b1;
				end
			end
			classConst: begin
				decode.word.aluSrc = 1'b1;
				decode.word.regWrite = 1'b1;
				case (funcField[1:0])
					2'b00: begin
						decode.known = 1'b1;
						decode.word.aluOp = aluPassB;
					end
					2'b01: begin
						decode.known = 1'b1;
						decode.word.aluOp = aluLch;
						decode.word.signExt = extHigh;
					end
					2'b10: begin
						decode.known = 1'b1;
						decode.word.aluOp = aluLcl;
						decode.word.signExt = extLow;
					end
					default: begin
						decode.known = 1'b0;
					end
				endcase
			end
			classBranch: begin
				decode.word.branch = 1'b1;
				decode.word.registerB = 1'b1;
				case (funcField[4:2])
					3'b001: begin
						decode.known = 1'b1;
						decode.word.aluOp = aluBeq;
					end
					3'b010: begin
						decode.known = 1'b1;
						decode.word.aluOp = aluBne;
					end
					default: begin
						decode.known = 1'b0;
					end
				endcase
			end
			classJump: begin
				if (!funcField[4]) begin
					decode.word.branch = 1'b1;
					case (funcField[3:0])
						4'b0000: begin
							decode.known = 1'b1;
							decode.word.aluSrc = 1'b1;
							decode.word.aluOp = aluJumpTarget;
						end
						4'b0001: begin
							decode.known = 1'b1;
							decode.word.memToReg = fromPc;
							decode.word.regWrite = 1'b1;
						end
						4'b0010: begin
							decode.known = 1'b1;
							decode.word.jumpRegister = 1'b1;
							decode.word.aluOp = aluPassA;
						end
						default: begin
							decode.known = 1'b0;
						end
					endcase
				end else begin
					// Branch filled in by the register stage from taken
					decode.word = condJumpWord;
					decode.word.branch = 1'b0;
					decode.condJump = 1'b1;
					decode.known = (decode.cond <= jfCarry);
				end
			end
			default: begin
				decode.known = 1'b0;
			end
		endcase
	end

	always_comb begin
		if (decode.known) begin
			assert (decode.word.memReadN || decode.word.memWriteN)
				else $error("decoder raised both memory strobes");
		end
	end

endmodule

`default_nettype wire

//--- hdl/controlWordReg.sv
`timescale 1ns/10ps
`default_nettype none

module controlWordReg import controlPkg::*; (
	input logic clock,
	input logic rst,
	input logic taken,
	decodeIf.stage decode,
	output logic branch,
	output logic memReadN,
	output logic memWriteN,
	output memToReg_e memToReg,
	output aluOp_e aluOp,
	output logic aluSrc,
	output logic regWrite,
	output logic registerB,
	output logic jumpRegister,
	output signExt_e signExt,
	output logic updateB
);

	controlWord_t nextWord;
	controlWord_t wordQ;

	always_comb begin
		nextWord = decode.word;
		if (decode.condJump) begin
			nextWord.branch = taken;
		end
	end

	// Unknown encodings hold everything including updateB
	always_ff @(posedge clock) begin
		if (rst) begin
			wordQ <= idleWord;
			updateB <= 1'b0;
		end else if (decode.known) begin
			wordQ <= nextWord;
			updateB <= ~updateB;
		end
	end

	assign branch = wordQ.branch;
	assign memReadN = wordQ.memReadN;
	assign memWriteN = wordQ.memWriteN;
	assign memToReg = wordQ.memToReg;
	assign aluOp = wordQ.aluOp;
	assign aluSrc = wordQ.aluSrc;
	assign regWrite = wordQ.regWrite;
	assign registerB = wordQ.registerB;
	assign jumpRegister = wordQ.jumpRegister;
	assign signExt = wordQ.signExt;

	assert property (@(posedge clock) rst |=> ({branch, memReadN, memWriteN, memToReg,
			aluOp, aluSrc, regWrite, registerB, jumpRegister, signExt} == idleWord)
			&& !updateB)
		else $error("outputs not idle after reset");

	assert property (@(posedge clock) disable iff (rst) memReadN || memWriteN)
		else $error("memReadN and memWriteN both active");

endmodule

`default_nettype wire

//--- hdl/controlUnit.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnit import controlPkg::*; (
	input logic clock,
	input logic rst,
	input logic [instrWidth-1:0] instruction,
	input logic zero,
	input logic overflow,
	input logic carry,
	input logic neg,
	output logic branch,
	output logic memReadN,
	output logic memWriteN,
	output memToReg_e memToReg,
	output aluOp_e aluOp,
	output logic aluSrc,
	output logic regWrite,
	output logic registerB,
	output logic jumpRegister,
	output signExt_e signExt,
	output logic updateB
);

	logic taken;

	decodeIf decodeBus ();

	instrDecoder decoder (
		.decode(decodeBus.decoder),
		.instruction(instruction)
	);

	jumpCondition condCheck (
		.decode(decodeBus.check),
		.zero(zero),
		.overflow(overflow),
		.carry(carry),
		.neg(neg),
		.taken(taken)
	);

	controlWordReg wordReg (
		.clock(clock),
		.rst(rst),
		.taken(taken),
		.decode(decodeBus.stage),
		.branch(branch),
		.memReadN(memReadN),
		.memWriteN(memWriteN),
		.memToReg(memToReg),
		.aluOp(aluOp),
		.aluSrc(aluSrc),
		.regWrite(regWrite),
		.registerB(registerB),
		.jumpRegister(jumpRegister),
		.signExt(signExt),
		.updateB(updateB)
	);

endmodule

`default_nettype wire

//--- bench/controlUnitTb.sv
`timescale 1ns/10ps
`default_nettype none

module controlUnitTb import controlPkg::*; ();

	localparam int randomCount = 300;
	// Reset, ALU, constants, branches, condition sweep, unknowns, random, test flushes
	localparam int totalCycles = 10 + 34 + 5 + 5 + 160 + 8 + randomCount + 12;

	logic clock, rst, zero, overflow, carry, neg;
	logic [instrWidth-1:0] instruction;
	logic branch, memReadN, memWriteN, aluSrc, regWrite, registerB, jumpRegister, updateB;
	memToReg_e memToReg;
	aluOp_e aluOp;
	signExt_e signExt;

	controlWord_t expWord;
	logic expUpd;
	logic expValid = 1'b0;
	int errorCount = 0;
	int testCount = 0;
	int testErrStart = 0;

	controlUnit dut0 (.clock(clock), .rst(rst), .instruction(instruction), .zero(zero),
		.overflow(overflow), .carry(carry), .neg(neg), .branch(branch), .memReadN(memReadN),
		.memWriteN(memWriteN), .memToReg(memToReg), .aluOp(aluOp), .aluSrc(aluSrc),
		.regWrite(regWrite), .registerB(registerB), .jumpRegister(jumpRegister),
		.signExt(signExt), .updateB(updateB));

	always #2 clock = ~clock;

	function automatic logic conditionTaken(input logic [3:0] cd, input logic z, o, c, n);
		case (cd)
			4'd0: return z;
			4'd1: return o;
			4'd2: return n;
			4'd3: return n | z;
			4'd4: return c;
			4'd5: return !z;
			4'd6: return !o;
			4'd7: return !n;
			// jf on negzero is not the inverse of jt
			4'd8: return !n | !z;
			4'd9: return !c;
			default: return 1'b0;
		endcase
	endfunction

	function automatic void predictWord(input logic [31:0] instr, input logic z, o, c, n,
			output controlWord_t w, output logic known);
		logic [2:0] cls;
		logic [4:0] fn;
		logic [3:0] cd;
		cls = instr[classMsb:classLsb];
		fn = instr[funcMsb:funcLsb];
		cd = instr[condMsb:condLsb];
		w = idleWord;
		known = 1'b0;
		if (cls == 3'b000) begin
			known = 1'b1;
		end else if (cls == 3'b001) begin
			known = !(fn inside {5'd2, 5'd7, [5'd10:5'd15]});
			w.aluOp = aluOp_e'(fn);
			w.regWrite = 1'b1;
		end else if (cls == 3'b100) begin
			known = 1'b1;
			w.aluSrc = 1'b1;
			w.memReadN = fn[0];
			w.memWriteN = !fn[0];
			w.memToReg = fn[0] ? fromAlu : fromMem;
			w.regWrite = !fn[0];
			w.registerB = fn[0];
		end else if (cls == 3'b010) begin
			known = fn[1:0] != 2'b11;
			w.aluSrc = 1'b1;
			w.regWrite = 1'b1;
			w.aluOp = fn[1] ? aluLcl : (fn[0] ? aluLch : aluPassB);
			w.signExt = fn[1] ? extLow : (fn[0] ? extHigh : extNone);
		end else if (cls == 3'b101) begin
			known = fn[4:2] == 3'b001 || fn[4:2] == 3'b010;
			w.branch = 1'b1;
			w.registerB = 1'b1;
			w.aluOp = fn[3] ? aluBne : aluBeq;
		end else if (cls == 3'b110 && !fn[4]) begin
			known = fn[3:0] <= 4'd2;
			w.branch = 1'b1;
			w.aluSrc = fn[3:0] == 4'd0;
			w.aluOp = fn[3:0] == 4'd0 ? aluJumpTarget : (fn[3:0] == 4'd2 ? aluPassA : aluAdd);
			w.memToReg = fn[3:0] == 4'd1 ? fromPc : fromAlu;
			w.regWrite = fn[3:0] == 4'd1;
			w.jumpRegister = fn[3:0] == 4'd2;
		end else if (cls == 3'b110) begin
			known = cd <= 4'd9;
			w = condJumpWord;
			w.branch = conditionTaken(cd, z, o, c, n);
		end
	endfunction

	// Expectation taken at the same edge that samples the inputs
	always @(posedge clock) begin : trackExpected
		controlWord_t w;
		logic k;
		predictWord(instruction, zero, overflow, carry, neg, w, k);
		if (rst) begin
			expWord <= idleWord;
			expUpd <= 1'b0;
		end else if (k) begin
			expWord <= w;
			expUpd <= !expUpd;
		end
		expValid <= 1'b1;
	end

	task automatic reportMismatch(input string field);
		errorCount++;
		$display("MISMATCH at %0t: %s differs from the expected value", $time, field);
	endtask

	assert property (@(posedge clock) expValid |-> branch == expWord.branch)
		else reportMismatch("branch");
	assert property (@(posedge clock) expValid |-> memReadN == expWord.memReadN)
		else reportMismatch("memReadN");
	assert property (@(posedge clock) expValid |-> memWriteN == expWord.memWriteN)
		else reportMismatch("memWriteN");
	assert property (@(posedge clock) expValid |-> memToReg == expWord.memToReg)
		else reportMismatch("memToReg");
	assert property (@(posedge clock) expValid |-> aluOp == expWord.aluOp)
		else reportMismatch("aluOp");
	assert property (@(posedge clock) expValid |-> aluSrc == expWord.aluSrc)
		else reportMismatch("aluSrc");
	assert property (@(posedge clock) expValid |-> regWrite == expWord.regWrite)
		else reportMismatch("regWrite");
	assert property (@(posedge clock) expValid |-> registerB == expWord.registerB)
		else reportMismatch("registerB");
	assert property (@(posedge clock) expValid |-> jumpRegister == expWord.jumpRegister)
		else reportMismatch("jumpRegister");
	assert property (@(posedge clock) expValid |-> signExt == expWord.signExt)
		else reportMismatch("signExt");
	assert property (@(posedge clock) expValid |-> updateB == expUpd)
		else reportMismatch("updateB");

	task automatic applyInputs(input logic [31:0] instr, input logic [3:0] flags);
		@(negedge clock);
		instruction = instr;
		{zero, overflow, carry, neg} = flags;
	endtask

	// Two more edges so the last word gets sampled and then checked
	task automatic endTest(input string name);
		repeat (2) @(negedge clock);
		testCount++;
		$display("test %0d %s: %0d errors", testCount, name, errorCount - testErrStart);
		testErrStart = errorCount;
	endtask

	initial begin
		#(totalCycles * 4 + 200);
		$display("Timeout: the tests did not finish in time");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		clock = 1'b0;
		rst = 1'b1;
		instruction = '0;
		{zero, overflow, carry, neg} = 4'b0000;
		void'($urandom(32'hfb8b26f8));
		repeat (10) @(negedge clock);
		rst = 1'b0;
		endTest("reset");
		for (int i = 0; i < 32; i++)
			applyInputs({3'b001, 5'(i), 24'($urandom)}, 4'($urandom));
		applyInputs({3'b100, 4'($urandom), 1'b0, 24'($urandom)}, 4'($urandom));
		applyInputs({3'b100, 4'($urandom), 1'b1, 24'($urandom)}, 4'($urandom));
		endTest("alu and memory");
		for (int i = 0; i < 4; i++)
			applyInputs({3'b010, 3'($urandom), 2'(i), 24'($urandom)}, 4'($urandom));
		applyInputs({3'b000, 29'($urandom)}, 4'($urandom));
		endTest("constants and nop");
		applyInputs({3'b101, 3'b001, 26'($urandom)}, 4'($urandom));
		applyInputs({3'b101, 3'b010, 26'($urandom)}, 4'($urandom));
		for (int i = 0; i < 3; i++)
			applyInputs({3'b110, 1'b0, 4'(i), 24'($urandom)}, 4'($urandom));
		endTest("branches and jumps");
		for (int cd = 0; cd < 10; cd++)
			for (int f = 0; f < 16; f++)
				applyInputs({3'b110, 1'b1, 2'($urandom), 4'(cd), 22'($urandom)}, 4'(f));
		endTest("conditional jumps");
		applyInputs({3'b011, 29'($urandom)}, 4'($urandom));
		applyInputs({3'b111, 29'($urandom)}, 4'($urandom));
		applyInputs({3'b101, 3'b000, 26'($urandom)}, 4'($urandom));
		applyInputs({3'b110, 1'b0, 4'd3, 24'($urandom)}, 4'($urandom));
		applyInputs({3'b110, 1'b1, 2'($urandom), 4'd12, 22'($urandom)}, 4'($urandom));
		applyInputs({3'b001, 5'd13, 24'($urandom)}, 4'($urandom));
		applyInputs({3'b010, 3'($urandom), 2'b11, 24'($urandom)}, 4'($urandom));
		applyInputs({3'b001, 5'd10, 24'($urandom)}, 4'($urandom));
		for (int i = 0; i < randomCount; i++)
			applyInputs($urandom, 4'($urandom));
		endTest("unknown and random");
		$display("%0d tests run, %0d failed checks", testCount, errorCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- controlUnit.f
hdl/controlPkg.sv
hdl/decodeIf.sv
hdl/jumpCondition.sv
hdl/instrDecoder.sv
hdl/controlWordReg.sv
hdl/controlUnit.sv
bench/controlUnitTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the control unit testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --timing --assert --top-module controlUnitTb -Mdir obj_dir -f controlUnit.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VcontrolUnitTb > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -qF '*** PASSED ***' "$logFile"; then
	exit 0
fi
exit 1
